/* sources.f */
rtl/pi_bus_pkg.sv
rtl/pi_master.sv
rtl/pi_arbiter.sv
rtl/pi_slave_fsm.sv
rtl/pi_storage.sv
rtl/pi_bus_top.sv
tests/pi_bus_asserts.sv
tests/pi_bus_tb.sv

/* tests/pi_bus_tb.sv */
// testbench for the processor-interface bus with random commands and a memory model
`timescale 1ns/1ns
`default_nettype none

module pi_bus_tb
   import pi_bus_pkg::*;
();

   localparam int          NUM_CMDS   = 80;
   localparam int          WAIT_LIMIT = 300;
   localparam logic [31:0] SEED       = 32'h25aa;

   logic              clk;
   logic              rst_n;
   logic              cmd_valid [2];
   logic              cmd_write [2];
   logic              cmd_lock  [2];
   logic [ADDR_W-1:0] cmd_addr  [2];
   logic [DATA_W-1:0] cmd_wdata [2];
   logic              cmd_ready [2];
   logic              rsp_valid [2];
   logic [DATA_W-1:0] rsp_rdata [2];
   logic              rsp_err   [2];

   logic [DATA_W-1:0] model [MEM_WORDS];
   logic              lock_hold [2];
   logic              abort;
   int                errors;
   int                assert_errors;

   pi_bus_top i_dut (
      .clk, .rst_n,
      .cmd_valid_0(cmd_valid[0]), .cmd_write_0(cmd_write[0]), .cmd_lock_0(cmd_lock[0]),
      .cmd_addr_0(cmd_addr[0]), .cmd_wdata_0(cmd_wdata[0]), .cmd_ready_0(cmd_ready[0]),
      .rsp_valid_0(rsp_valid[0]), .rsp_rdata_0(rsp_rdata[0]), .rsp_err_0(rsp_err[0]),
      .cmd_valid_1(cmd_valid[1]), .cmd_write_1(cmd_write[1]), .cmd_lock_1(cmd_lock[1]),
      .cmd_addr_1(cmd_addr[1]), .cmd_wdata_1(cmd_wdata[1]), .cmd_ready_1(cmd_ready[1]),
      .rsp_valid_1(rsp_valid[1]), .rsp_rdata_1(rsp_rdata[1]), .rsp_err_1(rsp_err[1])
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   task automatic report_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
      errors++;
      $display("Fail at %0t ns: %s = %h, expected %h", $time, name, got, exp);
   endtask

   task automatic report_problem(input string msg);
      errors++;
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   // compare one response with the model, called in the rsp_valid cycle
   task automatic check_response(input int m, input logic [ADDR_W-1:0] addr, input logic write,
                                 input logic [DATA_W-1:0] data, input logic lock);
      if (lock_hold[1-m]) begin
         report_problem($sformatf("master %0d finished inside a locked sequence of master %0d",
                                  m, 1 - m));
      end
      // a locked command keeps the bus for the same master's next command
      lock_hold[m] = lock;
      if (!cmd_ready[m]) begin
         report_problem($sformatf("cmd_ready_%0d low in the response cycle", m));
      end
      if (addr >= ERR_BASE) begin
         if (rsp_err[m] !== 1'b1) begin
            report_value($sformatf("rsp_err_%0d", m), DATA_W'(rsp_err[m]), DATA_W'(1));
         end
      end else begin
         if (rsp_err[m] !== 1'b0) begin
            report_value($sformatf("rsp_err_%0d", m), DATA_W'(rsp_err[m]), DATA_W'(0));
         end
         if (write) begin
            model[addr[MEM_AW-1:0]] = data;
         end else if (rsp_rdata[m] !== model[addr[MEM_AW-1:0]]) begin
            report_value($sformatf("rsp_rdata_%0d", m), rsp_rdata[m], model[addr[MEM_AW-1:0]]);
         end
      end
   endtask

   // random command stream for one master, one command in flight
   task automatic run_master(input int m);
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
      logic              write;
      logic              lock;
      int                region;
      int                gap;
      int                cnt;
      logic              seen;
      for (int n = 0; n < NUM_CMDS; n++) begin
         if (abort) return;
         region = $urandom_range(9);
         if (region < 6) begin
            addr = ADDR_W'($urandom_range(MEM_WORDS - 1));
         end else if (region < 8) begin
            addr = ADDR_W'($urandom_range(DEAD_BASE - 1, ERR_BASE));
         end else begin
            addr = ADDR_W'($urandom_range(2**ADDR_W - 1, DEAD_BASE));
         end
         write = 1'($urandom_range(1));
         data  = $urandom();
         // locked commands always get a follow-up and never end in timeout
         lock  = (n < NUM_CMDS - 1) && (addr < DEAD_BASE) && ($urandom_range(5) == 0);
         gap   = $urandom_range(1) ? 0 : $urandom_range(4, 1);
         repeat (gap) begin
            @(negedge clk);
            if (rsp_valid[m]) report_problem($sformatf("rsp_valid_%0d with no command", m));
         end
         @(posedge clk);
         #1;
         cmd_valid[m] = 1'b1;
         cmd_write[m] = write;
         cmd_lock[m]  = lock;
         cmd_addr[m]  = addr;
         cmd_wdata[m] = data;
         cnt  = 0;
         seen = 1'b0;
         while (!seen && !abort) begin
            @(negedge clk);
            cnt++;
            seen = cmd_ready[m];
            if (rsp_valid[m]) report_problem($sformatf("rsp_valid_%0d with no command", m));
            if (!seen && cnt >= WAIT_LIMIT) begin
               report_problem($sformatf("timeout waiting for cmd_ready_%0d", m));
               abort = 1'b1;
            end
         end
         @(posedge clk);
         #1;
         cmd_valid[m] = 1'b0;
         cnt  = 0;
         seen = 1'b0;
         while (!seen && !abort) begin
            @(negedge clk);
            cnt++;
            seen = rsp_valid[m];
            if (!seen && cmd_ready[m]) begin
               report_problem($sformatf("cmd_ready_%0d high before the response", m));
            end
            if (!seen && cnt >= WAIT_LIMIT) begin
               report_problem($sformatf("timeout waiting for rsp_valid_%0d", m));
               abort = 1'b1;
            end
         end
         if (seen) check_response(m, addr, write, data, lock);
      end
   endtask

   initial begin
      errors = 0;
      abort  = 1'b0;
      rst_n  = 1'b0;
      for (int m = 0; m < 2; m++) begin
         cmd_valid[m] = 1'b0;
         cmd_write[m] = 1'b0;
         cmd_lock[m]  = 1'b0;
         cmd_addr[m]  = '0;
         cmd_wdata[m] = '0;
         lock_hold[m] = 1'b0;
      end
      for (int i = 0; i < MEM_WORDS; i++) begin
         model[i] = '0;
      end
      void'($urandom(SEED));
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      // idle bus straight after reset
      repeat (4) begin
         @(negedge clk);
         if (!cmd_ready[0] || !cmd_ready[1]) report_problem("cmd_ready low after reset");
         if (rsp_valid[0] || rsp_valid[1]) report_problem("rsp_valid with no command given");
      end
      fork
         run_master(0);
         run_master(1);
      join
      repeat (4) @(negedge clk);
      assert_errors = i_dut.i_arbiter.i_asserts.fail_count;
      $display("check errors: %0d, assertion failures: %0d", errors, assert_errors);
      if (errors == 0 && assert_errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tests/pi_bus_asserts.sv */
// bound checks on the arbiter grant, select and timeout behaviour
`timescale 1ns/1ns
`default_nettype none

module pi_bus_asserts (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic req_0,
   input wire logic req_1,
   input wire logic gnt_0,
   input wire logic gnt_1,
   input wire logic sel,
   input wire logic timeout
);

   // number of failed assertions so far
   int fail_count = 0;

   // only one master owns the bus
   one_owner: assert property (@(posedge clk) disable iff (!rst_n) !(gnt_0 && gnt_1))
      else begin
         fail_count++;
         $error("both grants high in the same cycle");
      end

   // the slave is selected only for a granted master that still requests
   sel_granted: assert property (@(posedge clk) disable iff (!rst_n)
                                 sel |-> ((gnt_0 && req_0) || (gnt_1 && req_1)))
      else begin
         fail_count++;
         $error("sel high without a granted and requesting master");
      end

   // timeout is a single pulse and frees the bus
   timeout_frees: assert property (@(posedge clk) disable iff (!rst_n)
                                    timeout |=> (!timeout && !gnt_0 && !gnt_1))
      else begin
         fail_count++;
         $error("timeout not followed by a free bus");
      end

endmodule

bind pi_arbiter pi_bus_asserts i_asserts (
   .clk(clk), .rst_n(rst_n), .req_0(req_0), .req_1(req_1),
   .gnt_0(gnt_0), .gnt_1(gnt_1), .sel(sel), .timeout(timeout)
);

`default_nettype wire

/* rtl/pi_bus_top.sv */
// processor-interface bus top level with two masters, arbiter, slave and storage
`timescale 1ns/1ns
`default_nettype none

module pi_bus_top
   import pi_bus_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              cmd_valid_0,
   input  wire logic              cmd_write_0,
   input  wire logic              cmd_lock_0,
   input  wire logic [ADDR_W-1:0] cmd_addr_0,
   input  wire logic [DATA_W-1:0] cmd_wdata_0,
   output logic                   cmd_ready_0,
   output logic                   rsp_valid_0,
   output logic [DATA_W-1:0]      rsp_rdata_0,
   output logic                   rsp_err_0,
   input  wire logic              cmd_valid_1,
   input  wire logic              cmd_write_1,
   input  wire logic              cmd_lock_1,
   input  wire logic [ADDR_W-1:0] cmd_addr_1,
   input  wire logic [DATA_W-1:0] cmd_wdata_1,
   output logic                   cmd_ready_1,
   output logic                   rsp_valid_1,
   output logic [DATA_W-1:0]      rsp_rdata_1,
   output logic                   rsp_err_1
);

   // master to arbiter
   logic              req_0, req_1;
   logic              gnt_0, gnt_1;
   logic              lock_0, lock_1;
   logic              write_0, write_1;
   logic [ADDR_W-1:0] addr_0, addr_1;
   logic [DATA_W-1:0] wdata_0, wdata_1;

   // shared bus
   logic              sel;
   logic              timeout;
   logic [ACK_W-1:0]  ack;
   logic [DATA_W-1:0] rdata;
   logic [ADDR_W-1:0] bus_addr;
   logic              bus_write;
   logic [DATA_W-1:0] bus_wdata;

   // slave to storage
   logic              mem_start, mem_done, mem_err, mem_write;
   logic [ADDR_W-1:0] mem_addr;
   logic [DATA_W-1:0] mem_wdata, mem_rdata;

   pi_master i_master_0 (
      .clk, .rst_n,
      .cmd_valid(cmd_valid_0), .cmd_write(cmd_write_0), .cmd_lock(cmd_lock_0),
      .cmd_addr(cmd_addr_0), .cmd_wdata(cmd_wdata_0), .cmd_ready(cmd_ready_0),
      .rsp_valid(rsp_valid_0), .rsp_rdata(rsp_rdata_0), .rsp_err(rsp_err_0),
      .req(req_0), .lock(lock_0), .addr(addr_0), .write(write_0), .wdata(wdata_0),
      .gnt(gnt_0), .ack, .rdata, .timeout
   );

   pi_master i_master_1 (
      .clk, .rst_n,
      .cmd_valid(cmd_valid_1), .cmd_write(cmd_write_1), .cmd_lock(cmd_lock_1),
      .cmd_addr(cmd_addr_1), .cmd_wdata(cmd_wdata_1), .cmd_ready(cmd_ready_1),
      .rsp_valid(rsp_valid_1), .rsp_rdata(rsp_rdata_1), .rsp_err(rsp_err_1),
      .req(req_1), .lock(lock_1), .addr(addr_1), .write(write_1), .wdata(wdata_1),
      .gnt(gnt_1), .ack, .rdata, .timeout
   );

   pi_arbiter i_arbiter (
      .clk, .rst_n,
      .req_0, .req_1, .lock_0, .lock_1, .addr_0, .addr_1,
      .write_0, .write_1, .wdata_0, .wdata_1, .ack,
      .gnt_0, .gnt_1, .sel, .bus_addr, .bus_write, .bus_wdata, .timeout
   );

   pi_slave_fsm i_slave (
      .clk, .rst_n,
      .sel, .bus_addr, .bus_write, .bus_wdata, .timeout,
      .mem_done, .mem_err, .mem_rdata,
      .ack, .rdata, .mem_start, .mem_addr, .mem_write, .mem_wdata
   );

   pi_storage i_storage (
      .clk, .rst_n,
      .mem_start, .mem_addr, .mem_write, .mem_wdata,
      .mem_done, .mem_rdata, .mem_err
   );

endmodule

`default_nettype wire

/* rtl/pi_storage.sv */
// word storage with address-dependent wait states, an error region and a dead region
`timescale 1ns/1ns
`default_nettype none

module pi_storage
   import pi_bus_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              mem_start,
   input  wire logic [ADDR_W-1:0] mem_addr,
   input  wire logic              mem_write,
   input  wire logic [DATA_W-1:0] mem_wdata,
   output logic                   mem_done,
   output logic [DATA_W-1:0]      mem_rdata,
   output logic                   mem_err
);

   logic [DATA_W-1:0] mem [MEM_WORDS];
   logic              pending;
   logic [1:0]        wait_cnt;
   logic              in_err;
   logic              in_dead;
   logic [MEM_AW-1:0] idx_q;
   logic              write_q;
   logic [DATA_W-1:0] wdata_q;

   assign in_err  = (mem_addr >= ADDR_W'(ERR_BASE)) && (mem_addr < ADDR_W'(DEAD_BASE));
   assign in_dead = (mem_addr >= ADDR_W'(DEAD_BASE));

   assign mem_done  = pending && (wait_cnt == 2'd0);
   assign mem_rdata = mem[idx_q];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pending  <= 1'b0;
         wait_cnt <= 2'd0;
      end else if (mem_start) begin
         // dead region never starts a countdown
         pending  <= !in_dead;
         wait_cnt <= in_err ? 2'd0 : mem_addr[1:0];
      end else if (mem_done) begin
         pending <= 1'b0;
      end else if (pending) begin
         wait_cnt <= wait_cnt - 2'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (mem_start) begin
         idx_q   <= mem_addr[MEM_AW-1:0];
         write_q <= mem_write;
         wdata_q <= mem_wdata;
         mem_err <= in_err;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (mem_done && write_q && !mem_err) begin
         mem[idx_q] <= wdata_q;
      end
   end

endmodule

`default_nettype wire

/* rtl/pi_slave_fsm.sv */
// slave state machine decoding a selected transfer and driving the acknowledge code
`timescale 1ns/1ns
`default_nettype none

module pi_slave_fsm
   import pi_bus_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              sel,
   input  wire logic [ADDR_W-1:0] bus_addr,
   input  wire logic              bus_write,
   input  wire logic [DATA_W-1:0] bus_wdata,
   input  wire logic              timeout,
   input  wire logic              mem_done,
   input  wire logic              mem_err,
   input  wire logic [DATA_W-1:0] mem_rdata,
   output logic [ACK_W-1:0]       ack,
   output logic [DATA_W-1:0]      rdata,
   output logic                   mem_start,
   output logic [ADDR_W-1:0]      mem_addr,
   output logic                   mem_write,
   output logic [DATA_W-1:0]      mem_wdata
);

   typedef enum logic [1:0] {
      S_IDLE,
      S_START,
      S_WAIT,
      S_REPLY
   } state_t;

   state_t            state;
   logic              err_q;
   logic [ADDR_W-1:0] addr_q;
   logic              write_q;
   logic [DATA_W-1:0] wdata_q;
   logic              latch;

   assign latch = (state == S_IDLE) && sel;

   assign mem_start = (state == S_START);
   assign mem_addr  = addr_q;
   assign mem_write = write_q;
   assign mem_wdata = wdata_q;

   always_comb begin
      case (state)
         S_START, S_WAIT: ack = ACK_WAT;
         S_REPLY:         ack = err_q ? ACK_ERR : ACK_RDY;
         default:         ack = ACK_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= S_IDLE;
      end else begin
         case (state)
            S_IDLE: begin
               if (sel) begin
                  state <= S_START;
               end
            end
            S_START: state <= timeout ? S_IDLE : S_WAIT;
            S_WAIT: begin
               // the arbiter gave up on this transfer
               if (timeout) begin
                  state <= S_IDLE;
               end else if (mem_done) begin
                  state <= S_REPLY;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (latch) begin
         addr_q  <= bus_addr;
         write_q <= bus_write;
         wdata_q <= bus_wdata;
      end
      if ((state == S_WAIT) && mem_done) begin
         err_q <= mem_err;
         rdata <= mem_rdata;
      end
   end

endmodule

`default_nettype wire

/* rtl/pi_arbiter.sv */
// round-robin bus arbiter with lock, granted-master bus multiplexer and transfer timeout
`timescale 1ns/1ns
`default_nettype none

module pi_arbiter
   import pi_bus_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst_n,
   input  wire logic              req_0,
   input  wire logic              req_1,
   input  wire logic              lock_0,
   input  wire logic              lock_1,
   input  wire logic [ADDR_W-1:0] addr_0,
   input  wire logic [ADDR_W-1:0] addr_1,
   input  wire logic              write_0,
   input  wire logic              write_1,
   input  wire logic [DATA_W-1:0] wdata_0,
   input  wire logic [DATA_W-1:0] wdata_1,
   input  wire logic [ACK_W-1:0]  ack,
   output logic                   gnt_0,
   output logic                   gnt_1,
   output logic                   sel,
   output logic [ADDR_W-1:0]      bus_addr,
   output logic                   bus_write,
   output logic [DATA_W-1:0]      bus_wdata,
   output logic                   timeout
);

   logic             busy;
   logic             done_q;
   logic             last_q;
   logic [TMO_W-1:0] tcnt;
   logic             owner_req;
   logic             owner_lock;
   logic             xfer_end;

   assign busy       = gnt_0 || gnt_1;
   assign owner_req  = gnt_1 ? req_1 : req_0;
   assign owner_lock = gnt_1 ? lock_1 : lock_0;

   // done_q marks a locked owner that has finished and keeps the bus
   assign sel      = busy && !done_q;
   assign xfer_end = sel && ((ack == ACK_RDY) || (ack == ACK_ERR));
   assign timeout  = sel && (tcnt == TMO_W'(TIMEOUT_CYCLES - 1));

   // bus fields come from the owner
   assign bus_addr  = gnt_1 ? addr_1 : addr_0;
   assign bus_write = gnt_1 ? write_1 : write_0;
   assign bus_wdata = gnt_1 ? wdata_1 : wdata_0;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         gnt_0  <= 1'b0;
         gnt_1  <= 1'b0;
         done_q <= 1'b0;
         last_q <= 1'b1;
      end else if (!busy) begin
         done_q <= 1'b0;
         // last_q high means master 1 was served last
         if (req_0 && (!req_1 || last_q)) begin
            gnt_0  <= 1'b1;
            last_q <= 1'b0;
         end else if (req_1) begin
            gnt_1  <= 1'b1;
            last_q <= 1'b1;
         end
      end else if (timeout) begin
         gnt_0  <= 1'b0;
         gnt_1  <= 1'b0;
         done_q <= 1'b0;
      end else if (xfer_end) begin
         if (owner_lock) begin
            done_q <= 1'b1;
         end else begin
            gnt_0 <= 1'b0;
            gnt_1 <= 1'b0;
         end
      end else if (done_q) begin
         // locked owner either starts its next command or lets go
         if (owner_req) begin
            done_q <= 1'b0;
         end else if (!owner_lock) begin
            gnt_0  <= 1'b0;
            gnt_1  <= 1'b0;
            done_q <= 1'b0;
         end
      end
   end

   // cycles since sel went high for the current transfer
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tcnt <= '0;
      end else if (!sel) begin
         tcnt <= '0;
      end else begin
         tcnt <= tcnt + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* rtl/pi_master.sv */
// bus master turning one external command into a bus transfer and returning its result
`timescale 1ns/1ns
`default_nettype none

module pi_master
   import pi_bus_pkg::*;
(
   input  wire logic              clk,
   input  wire logic              rst_n,
   // external command side
   input  wire logic              cmd_valid,
   input  wire logic              cmd_write,
   input  wire logic              cmd_lock,
   input  wire logic [ADDR_W-1:0] cmd_addr,
   input  wire logic [DATA_W-1:0] cmd_wdata,
   output logic                   cmd_ready,
   output logic                   rsp_valid,
   output logic [DATA_W-1:0]      rsp_rdata,
   output logic                   rsp_err,
   // bus side
   output logic                   req,
   output logic                   lock,
   output logic [ADDR_W-1:0]      addr,
   output logic                   write,
   output logic [DATA_W-1:0]      wdata,
   input  wire logic              gnt,
   input  wire logic [ACK_W-1:0]  ack,
   input  wire logic [DATA_W-1:0] rdata,
   input  wire logic              timeout
);

   typedef enum logic [1:0] {
      M_IDLE,
      M_REQ,
      M_XFER
   } state_t;

   state_t            state;
   logic              lock_q;
   logic              write_q;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic              take_cmd;
   logic              xfer_end;
   logic              xfer_bad;

   assign cmd_ready = (state == M_IDLE);
   assign take_cmd  = cmd_valid && cmd_ready;

   // only the granted master may treat ack or timeout as its own
   assign xfer_bad = (ack == ACK_ERR) || timeout;
   assign xfer_end = (state == M_XFER) && gnt && ((ack == ACK_RDY) || xfer_bad);

   assign req   = (state != M_IDLE);
   assign lock  = lock_q;
   assign addr  = addr_q;
   assign write = write_q;
   assign wdata = wdata_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= M_IDLE;
         lock_q    <= 1'b0;
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= 1'b0;
         case (state)
            M_IDLE: begin
               if (take_cmd) begin
                  // lock stays as given until the next command replaces it
                  lock_q <= cmd_lock;
                  state  <= M_REQ;
               end
            end
            M_REQ: begin
               if (gnt) begin
                  state <= M_XFER;
               end
            end
            M_XFER: begin
               if (xfer_end) begin
                  rsp_valid <= 1'b1;
                  state     <= M_IDLE;
               end
            end
            default: state <= M_IDLE;
         endcase
      end
   end

   // command fields and response payload
   always_ff @(posedge clk) begin
      if (take_cmd) begin
         addr_q  <= cmd_addr;
         write_q <= cmd_write;
         wdata_q <= cmd_wdata;
      end
      if (xfer_end) begin
         rsp_rdata <= rdata;
         rsp_err   <= xfer_bad;
      end
   end

endmodule

`default_nettype wire

/* rtl/pi_bus_pkg.sv */
// processor-interface bus package with widths, acknowledge codes, storage map and timeout limit
`default_nettype none

package pi_bus_pkg;

   // bus widths
   localparam int unsigned ADDR_W = 6;
   localparam int unsigned DATA_W = 32;
   localparam int unsigned ACK_W  = 3;

   // acknowledge codes
   localparam logic [ACK_W-1:0] ACK_IDLE = 3'd0;
   localparam logic [ACK_W-1:0] ACK_WAT  = 3'd1;
   localparam logic [ACK_W-1:0] ACK_ERR  = 3'd3;
   localparam logic [ACK_W-1:0] ACK_RDY  = 3'd4;

   // storage map
   // 0..15 real words, 16..31 answer with an error, 32..63 never answer
   localparam int unsigned MEM_WORDS = 16;
   localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);
   localparam int unsigned ERR_BASE  = 16;
   localparam int unsigned DEAD_BASE = 32;

   // cycles a granted transfer may go without RDY or ERR
   localparam int unsigned TIMEOUT_CYCLES = 12;
   localparam int unsigned TMO_W          = $clog2(TIMEOUT_CYCLES + 1);

endpackage

`default_nettype wire
